/* common/ada_mem_pkg.sv */
package ada_mem_pkg;

    // width of one memory word.
    localparam int DATA_W = 32;

    // word address width.
    localparam int ADDR_W = 8;

    // number of words in the shared RAM.
    localparam int DEPTH = 1 << ADDR_W;

    // one extra bit so a sum can span the whole memory.
    localparam int CNT_W = ADDR_W + 1;

    // load/store bus opcode.
    typedef enum logic {
        bus_read  = 1'b0,
        bus_write = 1'b1
    } bus_op_e;

    // debug host opcode.
    // code 3 is not assigned and is treated as a peek.
    typedef enum logic [1:0] {
        dbg_peek = 2'd0,
        dbg_poke = 2'd1,
        dbg_sum  = 2'd2
    } dbg_op_e;

    // bus port handshake states.
    typedef enum logic [1:0] {
        bus_idle   = 2'd0,
        bus_access = 2'd1,
        bus_ack    = 2'd2
    } bus_state_e;

    // debug port states.
    // the two sum states walk the address range and drain the pipeline.
    typedef enum logic [2:0] {
        dbg_idle     = 3'd0,
        dbg_access   = 3'd1,
        dbg_sum_run  = 3'd2,
        dbg_sum_last = 3'd3,
        dbg_ack      = 3'd4
    } dbg_state_e;

endpackage

/* debug_port/debug_port.sv */
`timescale 1ns/100ps

module debug_port (
    input  logic                            a_clk,
    input  logic                            rst,
    input  logic                            dbg_req,
    input  ada_mem_pkg::dbg_op_e            dbg_op,
    input  logic [ada_mem_pkg::ADDR_W-1:0]  dbg_addr,
    input  logic [ada_mem_pkg::CNT_W-1:0]   dbg_count,
    input  logic [ada_mem_pkg::DATA_W-1:0]  dbg_wdata,
    output logic                            dbg_ack,
    output logic [ada_mem_pkg::DATA_W-1:0]  dbg_rdata,
    output logic                            b_wr,
    output logic [ada_mem_pkg::ADDR_W-1:0]  b_addr,
    output logic [ada_mem_pkg::DATA_W-1:0]  b_din,
    input  logic [ada_mem_pkg::DATA_W-1:0]  b_dout
);

    ada_mem_pkg::dbg_state_e state;

    // opcode of the transaction in progress.
    ada_mem_pkg::dbg_op_e op_q;

    // sum walk address, wraps at DEPTH by its width.
    logic [ada_mem_pkg::ADDR_W-1:0] addr_q;

    // words still to be addressed in the sum walk.
    logic [ada_mem_pkg::CNT_W-1:0] remain_q;

    // running sum, wraps modulo 2**DATA_W.
    logic [ada_mem_pkg::DATA_W-1:0] acc_q;

    // set once the RAM output holds a word from the walk.
    logic rd_valid_q;

    logic start;

    assign start = (state == ada_mem_pkg::dbg_idle) && dbg_req;

    // peek and poke hit the RAM on the edge that samples the request.
    // during a sum walk the counter owns the address.
    assign b_wr   = start && (dbg_op == ada_mem_pkg::dbg_poke);
    assign b_addr = (state == ada_mem_pkg::dbg_idle) ? dbg_addr : addr_q;
    assign b_din  = dbg_wdata;

    always_ff @(posedge a_clk) begin
        if (rst) begin
            state      <= ada_mem_pkg::dbg_idle;
            op_q       <= ada_mem_pkg::dbg_peek;
            addr_q     <= '0;
            remain_q   <= '0;
            acc_q      <= '0;
            rd_valid_q <= 1'b0;
            dbg_ack    <= 1'b0;
            dbg_rdata  <= '0;
        end else begin
            case (state)
                ada_mem_pkg::dbg_idle: begin
                    // latch the request and clear the walk state.
                    addr_q     <= dbg_addr;
                    remain_q   <= dbg_count;
                    acc_q      <= '0;
                    rd_valid_q <= 1'b0;
                    if (dbg_req) begin
                        op_q <= dbg_op;
                        // an empty sum finishes like a peek.
                        if (dbg_op == ada_mem_pkg::dbg_sum && dbg_count != '0) begin
                            state <= ada_mem_pkg::dbg_sum_run;
                        end else begin
                            state <= ada_mem_pkg::dbg_access;
                        end
                    end
                end
                ada_mem_pkg::dbg_access: begin
                    // single word result, or zero for an empty sum.
                    if (op_q == ada_mem_pkg::dbg_sum) begin
                        dbg_rdata <= '0;
                    end else begin
                        dbg_rdata <= b_dout;
                    end
                    dbg_ack <= 1'b1;
                    state   <= ada_mem_pkg::dbg_ack;
                end
                ada_mem_pkg::dbg_sum_run: begin
                    // one address per cycle.
                    // the word from the previous address arrives now.
                    if (rd_valid_q) begin
                        acc_q <= acc_q + b_dout;
                    end
                    rd_valid_q <= 1'b1;
                    addr_q     <= addr_q + 1'b1;
                    remain_q   <= remain_q - 1'b1;
                    if (remain_q == ada_mem_pkg::CNT_W'(1)) begin
                        state <= ada_mem_pkg::dbg_sum_last;
                    end
                end
                ada_mem_pkg::dbg_sum_last: begin
                    // last word drains out of the RAM pipeline.
                    dbg_rdata <= acc_q + b_dout;
                    dbg_ack   <= 1'b1;
                    state     <= ada_mem_pkg::dbg_ack;
                end
                ada_mem_pkg::dbg_ack: begin
                    // hold the result until the host drops req.
                    if (!dbg_req) begin
                        dbg_ack <= 1'b0;
                        state   <= ada_mem_pkg::dbg_idle;
                    end
                end
                default: begin
                    dbg_ack <= 1'b0;
                    state   <= ada_mem_pkg::dbg_idle;
                end
            endcase
        end
    end

endmodule

/* design/ada_bram.sv */
`timescale 1ns/100ps

module ada_bram (
    input  logic                            a_clk,
    input  logic                            a_wr,
    input  logic [ada_mem_pkg::ADDR_W-1:0]  a_addr,
    input  logic [ada_mem_pkg::DATA_W-1:0]  a_din,
    output logic [ada_mem_pkg::DATA_W-1:0]  a_dout,
    input  logic                            b_wr,
    input  logic [ada_mem_pkg::ADDR_W-1:0]  b_addr,
    input  logic [ada_mem_pkg::DATA_W-1:0]  b_din,
    output logic [ada_mem_pkg::DATA_W-1:0]  b_dout
);

    // word array shared by both ports.
    logic [ada_mem_pkg::DATA_W-1:0] mem [ada_mem_pkg::DEPTH];

    // power-up contents are all zero.
    initial begin
        for (int i = 0; i < ada_mem_pkg::DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // port a, write-first.
    // a write shows the new word on the output in the same cycle.
    always_ff @(posedge a_clk) begin
        if (a_wr) begin
            mem[a_addr] <= a_din;
            a_dout      <= a_din;
        end else begin
            a_dout      <= mem[a_addr];
        end
    end

    // port b, same behavior as port a.
    always_ff @(posedge a_clk) begin
        if (b_wr) begin
            mem[b_addr] <= b_din;
            b_dout      <= b_din;
        end else begin
            b_dout      <= mem[b_addr];
        end
    end

endmodule

/* design/ada_imem_top.sv */
`timescale 1ns/100ps

module ada_imem_top (
    input  logic                            a_clk,
    input  logic                            rst,
    input  logic                            bus_req,
    input  ada_mem_pkg::bus_op_e            bus_op,
    input  logic [ada_mem_pkg::ADDR_W-1:0]  bus_addr,
    input  logic [ada_mem_pkg::DATA_W-1:0]  bus_wdata,
    output logic                            bus_ack,
    output logic [ada_mem_pkg::DATA_W-1:0]  bus_rdata,
    input  logic                            dbg_req,
    input  ada_mem_pkg::dbg_op_e            dbg_op,
    input  logic [ada_mem_pkg::ADDR_W-1:0]  dbg_addr,
    input  logic [ada_mem_pkg::CNT_W-1:0]   dbg_count,
    input  logic [ada_mem_pkg::DATA_W-1:0]  dbg_wdata,
    output logic                            dbg_ack,
    output logic [ada_mem_pkg::DATA_W-1:0]  dbg_rdata
);

    // RAM port a, owned by the load/store bus.
    logic                           a_wr;
    logic [ada_mem_pkg::ADDR_W-1:0] a_addr;
    logic [ada_mem_pkg::DATA_W-1:0] a_din;
    logic [ada_mem_pkg::DATA_W-1:0] a_dout;

    // RAM port b, owned by the debug host.
    logic                           b_wr;
    logic [ada_mem_pkg::ADDR_W-1:0] b_addr;
    logic [ada_mem_pkg::DATA_W-1:0] b_din;
    logic [ada_mem_pkg::DATA_W-1:0] b_dout;

    mem_bus_port u_bus_port (
        .a_clk     (a_clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_op    (bus_op),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .a_wr      (a_wr),
        .a_addr    (a_addr),
        .a_din     (a_din),
        .a_dout    (a_dout)
    );

    ada_bram u_bram (
        .a_clk  (a_clk),
        .a_wr   (a_wr),
        .a_addr (a_addr),
        .a_din  (a_din),
        .a_dout (a_dout),
        .b_wr   (b_wr),
        .b_addr (b_addr),
        .b_din  (b_din),
        .b_dout (b_dout)
    );

    debug_port u_debug_port (
        .a_clk     (a_clk),
        .rst       (rst),
        .dbg_req   (dbg_req),
        .dbg_op    (dbg_op),
        .dbg_addr  (dbg_addr),
        .dbg_count (dbg_count),
        .dbg_wdata (dbg_wdata),
        .dbg_ack   (dbg_ack),
        .dbg_rdata (dbg_rdata),
        .b_wr      (b_wr),
        .b_addr    (b_addr),
        .b_din     (b_din),
        .b_dout    (b_dout)
    );

endmodule

/* design/mem_bus_port.sv */
`timescale 1ns/100ps

module mem_bus_port (
    input  logic                            a_clk,
    input  logic                            rst,
    input  logic                            bus_req,
    input  ada_mem_pkg::bus_op_e            bus_op,
    input  logic [ada_mem_pkg::ADDR_W-1:0]  bus_addr,
    input  logic [ada_mem_pkg::DATA_W-1:0]  bus_wdata,
    output logic                            bus_ack,
    output logic [ada_mem_pkg::DATA_W-1:0]  bus_rdata,
    output logic                            a_wr,
    output logic [ada_mem_pkg::ADDR_W-1:0]  a_addr,
    output logic [ada_mem_pkg::DATA_W-1:0]  a_din,
    input  logic [ada_mem_pkg::DATA_W-1:0]  a_dout
);

    ada_mem_pkg::bus_state_e state;

    // high only in the idle cycle where a new request is sampled.
    logic start;

    assign start = (state == ada_mem_pkg::bus_idle) && bus_req;

    // the RAM access is issued on the same edge that samples the request.
    // the write strobe is one cycle wide because the FSM leaves idle at once.
    assign a_wr   = start && (bus_op == ada_mem_pkg::bus_write);
    assign a_addr = bus_addr;
    assign a_din  = bus_wdata;

    always_ff @(posedge a_clk) begin
        if (rst) begin
            state     <= ada_mem_pkg::bus_idle;
            bus_ack   <= 1'b0;
            bus_rdata <= '0;
        end else begin
            case (state)
                ada_mem_pkg::bus_idle: begin
                    // wait for a request.
                    if (bus_req) begin
                        state <= ada_mem_pkg::bus_access;
                    end
                end
                ada_mem_pkg::bus_access: begin
                    // RAM output is valid now.
                    // on a write it echoes the stored word.
                    bus_rdata <= a_dout;
                    bus_ack   <= 1'b1;
                    state     <= ada_mem_pkg::bus_ack;
                end
                ada_mem_pkg::bus_ack: begin
                    // hold ack and data until the master drops req.
                    if (!bus_req) begin
                        bus_ack <= 1'b0;
                        state   <= ada_mem_pkg::bus_idle;
                    end
                end
                default: begin
                    bus_ack <= 1'b0;
                    state   <= ada_mem_pkg::bus_idle;
                end
            endcase
        end
    end

endmodule

/* dv/imem_tests.txt */
// each line holds iface, op, addr, count, wdata and expected result, all in hex.
// iface 0 is the bus, 1 the debug host, f ends the list; a bus count is extra req cycles.
0 0 0a 000 00000000 00000000
1 0 14 000 00000000 00000000
0 1 0a 000 deadbeef deadbeef
0 0 0a 000 00000000 deadbeef
1 1 1e 000 12345678 12345678
0 0 1e 000 00000000 12345678
0 1 28 000 cafef00d cafef00d
1 0 28 000 00000000 cafef00d
0 1 29 000 11111111 11111111
1 0 1e 000 00000000 12345678
0 0 0a 000 00000000 deadbeef
1 1 fe 000 00000001 00000001
1 1 ff 000 00000002 00000002
0 1 00 000 00000004 00000004
0 1 01 000 00000008 00000008
// sum from ff wrapping to 01.
1 2 fe 004 00000000 0000000f
0 1 80 000 f0000000 f0000000
0 1 81 000 20000000 20000000
1 1 82 000 00000005 00000005
// total overflows 32 bits.
1 2 80 003 00000000 10000005
1 2 05 000 00000000 00000000
// req held 5 cycles past ack.
0 0 28 005 00000000 cafef00d
1 0 28 000 00000000 cafef00d
0 0 29 000 00000000 11111111
// whole memory, all words written above.
1 2 37 100 00000000 dcf21699
f 0 00 000 00000000 00000000

/* dv/mem_checker.sv */
`timescale 1ns/100ps

module mem_checker (
    input  logic                            a_clk,
    input  logic                            rst,
    input  logic                            done,
    input  logic                            bus_req,
    input  logic                            bus_ack,
    input  logic [ada_mem_pkg::DATA_W-1:0]  bus_rdata,
    input  logic                            dbg_req,
    input  logic                            dbg_ack,
    input  logic [ada_mem_pkg::DATA_W-1:0]  dbg_rdata,
    output int                              errors
);

    localparam int FIELDS    = 6;
    localparam int MAX_TESTS = 64;

    logic [31:0] tests [MAX_TESTS*FIELDS];
    int          n_tests  = 0;
    int          idx      = 0;
    int          passes   = 0;

    // previous samples for edge detection.
    logic was_rst     = 1'b0;
    logic bus_ack_q   = 1'b0;
    logic dbg_ack_q   = 1'b0;
    logic bus_req_q   = 1'b0;
    logic dbg_req_q   = 1'b0;
    // set by a new req and cleared by its ack.
    logic bus_pending = 1'b0;
    logic dbg_pending = 1'b0;
    logic reported    = 1'b0;

    initial begin
        errors = 0;
        $readmemh("dv/imem_tests.txt", tests);
        while (n_tests < MAX_TESTS && tests[n_tests*FIELDS] !== 32'hf) begin
            n_tests++;
        end
    end

    // judge one rising ack against the current test.
    task automatic check_ack(input logic on_dbg, input logic req, input logic pending,
                             input logic [31:0] rdata);
        string name;
        name = on_dbg ? "dbg_rdata" : "bus_rdata";
        if (!req) begin
            $display("test %0d failed: %s side ack rose with no request", idx, name);
            errors++;
        end else if (!pending) begin
            $display("test %0d failed: %s side gave a second ack for one request", idx, name);
            errors++;
        end else if (idx >= n_tests) begin
            $display("an ack arrived on the %s side after the last test", name);
            errors++;
        end else if (tests[idx*FIELDS] != {31'b0, on_dbg}) begin
            $display("test %0d failed: ack came on the wrong interface (%s side)", idx, name);
            errors++;
            idx++;
        end else if (rdata !== tests[idx*FIELDS+5]) begin
            $display("error: %s expected 0x%08h got 0x%08h in test %0d",
                     name, tests[idx*FIELDS+5], rdata, idx);
            errors++;
            idx++;
        end else begin
            $display("test %0d passed: %s = 0x%08h", idx, name, rdata);
            passes++;
            idx++;
        end
    endtask

    always @(posedge a_clk) begin
        was_rst   <= rst;
        bus_ack_q <= bus_ack;
        dbg_ack_q <= dbg_ack;
        bus_req_q <= bus_req;
        dbg_req_q <= dbg_req;
        // both acks must be low once reset has been applied.
        if (was_rst && (bus_ack !== 1'b0 || dbg_ack !== 1'b0)) begin
            $display("an ack was not low right after reset");
            errors++;
        end
        if (bus_req && !bus_req_q) begin
            bus_pending <= 1'b1;
        end
        if (dbg_req && !dbg_req_q) begin
            dbg_pending <= 1'b1;
        end
        if (bus_ack && !bus_ack_q) begin
            check_ack(1'b0, bus_req, bus_pending, bus_rdata);
            bus_pending <= 1'b0;
        end
        if (dbg_ack && !dbg_ack_q) begin
            check_ack(1'b1, dbg_req, dbg_pending, dbg_rdata);
            dbg_pending <= 1'b0;
        end
        // ack has to stay up as long as req does.
        if (bus_ack_q && !bus_ack && bus_req) begin
            $display("test %0d failed: bus_ack dropped while bus_req was still high", idx);
            errors++;
        end
        if (dbg_ack_q && !dbg_ack && dbg_req) begin
            $display("test %0d failed: dbg_ack dropped while dbg_req was still high", idx);
            errors++;
        end
        if (done && !reported) begin
            if (idx != n_tests) begin
                $display("only %0d of %0d tests received an ack", idx, n_tests);
                errors++;
            end
            $display("tests %0d, passed %0d, errors %0d", n_tests, passes, errors);
            reported <= 1'b1;
        end
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

    // words per test line in the tests file.
    localparam int FIELDS    = 6;
    localparam int MAX_TESTS = 64;
    localparam int CLK_NS    = 4;

    logic                           a_clk;
    logic                           rst;
    logic                           bus_req;
    ada_mem_pkg::bus_op_e           bus_op;
    logic [ada_mem_pkg::ADDR_W-1:0] bus_addr;
    logic [ada_mem_pkg::DATA_W-1:0] bus_wdata;
    logic                           bus_ack;
    logic [ada_mem_pkg::DATA_W-1:0] bus_rdata;
    logic                           dbg_req;
    ada_mem_pkg::dbg_op_e           dbg_op;
    logic [ada_mem_pkg::ADDR_W-1:0] dbg_addr;
    logic [ada_mem_pkg::CNT_W-1:0]  dbg_count;
    logic [ada_mem_pkg::DATA_W-1:0] dbg_wdata;
    logic                           dbg_ack;
    logic [ada_mem_pkg::DATA_W-1:0] dbg_rdata;

    // raised once every test has been driven.
    logic done;
    int   errors;
    int   n_tests = 0;

    logic [31:0] tests [MAX_TESTS*FIELDS];

    ada_imem_top UUT (
        .a_clk     (a_clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_op    (bus_op),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .dbg_req   (dbg_req),
        .dbg_op    (dbg_op),
        .dbg_addr  (dbg_addr),
        .dbg_count (dbg_count),
        .dbg_wdata (dbg_wdata),
        .dbg_ack   (dbg_ack),
        .dbg_rdata (dbg_rdata)
    );

    mem_checker u_checker (
        .a_clk     (a_clk),
        .rst       (rst),
        .done      (done),
        .bus_req   (bus_req),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .dbg_req   (dbg_req),
        .dbg_ack   (dbg_ack),
        .dbg_rdata (dbg_rdata),
        .errors    (errors)
    );

    // 4 ns clock.
    initial begin
        a_clk = 1'b0;
        forever #(CLK_NS / 2) a_clk = ~a_clk;
    end

    function automatic logic [31:0] test_field(input int t, input int f);
        return tests[t*FIELDS+f];
    endfunction

    // one four-phase bus transaction.
    // the count column holds extra cycles of req after ack.
    task automatic run_bus(input int t);
        logic [31:0] op_word;
        logic [31:0] addr_word;
        op_word   = test_field(t, 1);
        addr_word = test_field(t, 2);
        @(posedge a_clk);
        bus_op    <= ada_mem_pkg::bus_op_e'(op_word[0]);
        bus_addr  <= addr_word[ada_mem_pkg::ADDR_W-1:0];
        bus_wdata <= test_field(t, 4);
        bus_req   <= 1'b1;
        @(posedge a_clk);
        while (!bus_ack) @(posedge a_clk);
        repeat (test_field(t, 3)) @(posedge a_clk);
        bus_req <= 1'b0;
        @(posedge a_clk);
        while (bus_ack) @(posedge a_clk);
    endtask

    // one four-phase debug transaction.
    // sum latency varies with count.
    task automatic run_debug(input int t);
        logic [31:0] op_word;
        logic [31:0] addr_word;
        logic [31:0] count_word;
        op_word    = test_field(t, 1);
        addr_word  = test_field(t, 2);
        count_word = test_field(t, 3);
        @(posedge a_clk);
        dbg_op    <= ada_mem_pkg::dbg_op_e'(op_word[1:0]);
        dbg_addr  <= addr_word[ada_mem_pkg::ADDR_W-1:0];
        dbg_count <= count_word[ada_mem_pkg::CNT_W-1:0];
        dbg_wdata <= test_field(t, 4);
        dbg_req   <= 1'b1;
        @(posedge a_clk);
        while (!dbg_ack) @(posedge a_clk);
        dbg_req <= 1'b0;
        @(posedge a_clk);
        while (dbg_ack) @(posedge a_clk);
    endtask

    initial begin
        rst       = 1'b1;
        done      = 1'b0;
        bus_req   = 1'b0;
        bus_op    = ada_mem_pkg::bus_read;
        bus_addr  = '0;
        bus_wdata = '0;
        dbg_req   = 1'b0;
        dbg_op    = ada_mem_pkg::dbg_peek;
        dbg_addr  = '0;
        dbg_count = '0;
        dbg_wdata = '0;
        $readmemh("dv/imem_tests.txt", tests);
        // the list ends at the first line with interface code f.
        while (n_tests < MAX_TESTS && tests[n_tests*FIELDS] !== 32'hf) begin
            n_tests++;
        end
        repeat (2) @(posedge a_clk);
        rst <= 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            if (test_field(t, 0) == 32'h0) begin
                run_bus(t);
            end else begin
                run_debug(t);
            end
        end
        done <= 1'b1;
        // give the checker time to print its counts.
        repeat (2) @(posedge a_clk);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog sized for a full memory sum in every test.
    initial begin
        longint limit_ns;
        wait (n_tests > 0);
        limit_ns = longint'(n_tests) * (ada_mem_pkg::DEPTH + 20) * CLK_NS;
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* list.f */
common/ada_mem_pkg.sv
design/ada_bram.sv
design/mem_bus_port.sv
debug_port/debug_port.sv
design/ada_imem_top.sv
dv/mem_checker.sv
dv/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_top -f list.f

sim_out=$(./obj_dir/Vtb_top)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Finished with no errors"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
